/* Makefile */
TOP := tbMemSubsystem
OBJ := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ)/V$(TOP): src.f $(wildcard hw/*.sv) $(wildcard bench/*.sv)
	verilator --binary --assert --top-module $(TOP) -f src.f -Mdir $(OBJ)

run: $(OBJ)/V$(TOP)
	-./$(OBJ)/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf $(OBJ) sim.log

/* bench/tbMemSubsystem.sv */
`timescale 1ns/1ps

module tbMemSubsystem;
    import memPkg::*;

    localparam int addrWidth = 16;
    typedef logic [addrWidth-1:0] addr_t;

    localparam addr_t dataBase = addr_t'(16'h0100);
    localparam int fillOps = 128;
    localparam int storeOps = 50;
    localparam int loadRounds = 30;
    localparam int partialRounds = 8;
    localparam int fetchTarget = 40;
    localparam int concOps = 60;
    localparam int freezeOps = 80;
    localparam int totalOps = fillOps + storeOps + 3 * loadRounds + 3 * partialRounds
                              + fetchTarget + concOps + freezeOps;
    localparam int timeoutCycles = 40 * totalOps + 200;

    logic       clk = 1'b0;
    logic       rst;
    logic       rdy = 1'b1;
    logic       ioBufferFull = 1'b0;
    logic       fetchEn;
    logic       pcLoad = 1'b0;
    addr_t      pcValue = '0;
    logic       instValid;
    word_t      instOut;
    addr_t      instPc;
    logic       bpValid;
    word_t      bpInst;
    logic       cmdValid;
    logic       cmdStore;
    accessLen_e cmdLen;
    addr_t      cmdAddr;
    word_t      cmdData;
    logic       lsBusy;
    logic       lsDone;
    word_t      lsRdata;

    byte_t       shadow [2**addrWidth];
    word_t       expQ [$];
    logic [31:0] seed;
    logic [31:0] freezeState = 32'hb620;
    logic [31:0] redirState = 32'hb620;
    logic [2:0]  freezeLeft = '0;
    logic        freezeOn;
    addr_t       expectedPc = '0;
    int          issued = 0;
    int          doneCount = 0;
    int          instCount = 0;
    int          cycles = 0;

    memSubsystem #(
        .addrWidth(addrWidth)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioBufferFull(ioBufferFull),
        .fetchEn     (fetchEn),
        .pcLoad      (pcLoad),
        .pcValue     (pcValue),
        .instValid   (instValid),
        .instOut     (instOut),
        .instPc      (instPc),
        .bpValid     (bpValid),
        .bpInst      (bpInst),
        .cmdValid    (cmdValid),
        .cmdStore    (cmdStore),
        .cmdLen      (cmdLen),
        .cmdAddr     (cmdAddr),
        .cmdData     (cmdData),
        .lsBusy      (lsBusy),
        .lsDone      (lsDone),
        .lsRdata     (lsRdata)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t fillWord(input addr_t a);
        return word_t'({a ^ addr_t'(16'h9e37), a});
    endfunction

    // zero-extended little-endian load from the shadow memory
    function automatic word_t refLoad(input addr_t a, input accessLen_e len);
        word_t w;
        w = '0;
        for (int k = 0; k < int'(len); k++) begin
            w[8*k +: 8] = shadow[a + addr_t'(k)];
        end
        return w;
    endfunction

    function automatic word_t refInst(input addr_t a);
        return {shadow[a + addr_t'(3)], shadow[a + addr_t'(2)],
                shadow[a + addr_t'(1)], shadow[a]};
    endfunction

    task automatic checkWord(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %08h, expected %08h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkPc(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %04h, expected %04h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0b, expected %0b", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one command, shadow updated at issue, then wait for its done pulse
    task automatic issueOp(input logic store, input accessLen_e len, input addr_t a,
                           input word_t data);
        if (store) begin
            for (int k = 0; k < int'(len); k++) begin
                shadow[a + addr_t'(k)] = data[8*k +: 8];
            end
            expQ.push_back('0);
        end else begin
            expQ.push_back(refLoad(a, len));
        end
        @(posedge clk);
        cmdValid <= 1'b1;
        cmdStore <= store;
        cmdLen   <= len;
        cmdAddr  <= a;
        cmdData  <= data;
        issued++;
        @(posedge clk);
        cmdValid <= 1'b0;
        wait (doneCount == issued);
    endtask

    task automatic drawAddr(output addr_t a);
        seed = lcgNext(seed);
        a = dataBase + addr_t'(seed[31:24] % 8'd253);
    endtask

    task automatic randomOp(input logic storeOnly);
        logic       isStore;
        accessLen_e len;
        addr_t      a;
        seed = lcgNext(seed);
        isStore = storeOnly || seed[31];
        case (seed[30:29])
            2'd0: len = LEN_BYTE;
            2'd1: len = LEN_HALF;
            default: len = LEN_WORD;
        endcase
        drawAddr(a);
        seed = lcgNext(seed);
        issueOp(isStore, len, a, seed);
    endtask

    // random freeze stretches of either kind
    always @(posedge clk) begin
        if (!freezeOn) begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end else if (freezeLeft != 3'd0) begin
            freezeLeft <= freezeLeft - 3'd1;
        end else begin
            freezeState = lcgNext(freezeState);
            freezeLeft   <= freezeState[31:29];
            rdy          <= !(freezeState[28] && freezeState[27]);
            ioBufferFull <= freezeState[28] && !freezeState[27];
        end
    end

    // redirect before the code region runs out, plus a few random ones
    always @(posedge clk) begin
        pcLoad <= 1'b0;
        if (fetchEn && !rst) begin
            redirState = lcgNext(redirState);
            if (expectedPc >= addr_t'(8'hc0) || redirState[31:27] == 5'd0) begin
                pcLoad  <= 1'b1;
                pcValue <= addr_t'({redirState[20:16], 2'b00});
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            checkFlag("bpValid", bpValid, instValid);
            // busy from the cycle after the command until its done pulse
            checkFlag("lsBusy", lsBusy, issued != doneCount && !cmdValid && !lsDone);
            if (instValid) begin
                checkPc("instPc", instPc, expectedPc);
                checkWord("instOut", instOut, refInst(expectedPc));
                checkWord("bpInst", bpInst, refInst(expectedPc));
                expectedPc = expectedPc + addr_t'(4);
                instCount++;
            end
            // a redirect seen at the next edge replaces the sequential pc
            if (pcLoad) begin
                expectedPc = pcValue;
            end
            if (lsDone) begin
                if (expQ.size() == 0) begin
                    $display("lsDone pulse at %0t with no command outstanding", $time);
                    $display("Test failed");
                    $fatal(1, "extra done pulse");
                end
                checkWord("lsRdata", lsRdata, expQ.pop_front());
                doneCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("timeout after %0d cycles with %0d of %0d commands done",
                     cycles, doneCount, issued);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        addr_t a;
        int    fetchMark;
        logic  streamOk;
        seed     = 32'hb620;
        rst      = 1'b1;
        fetchEn  = 1'b0;
        freezeOn = 1'b0;
        cmdValid = 1'b0;
        cmdStore = 1'b0;
        cmdLen   = LEN_WORD;
        cmdAddr  = '0;
        cmdData  = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // code region and data region
        for (int i = 0; i < fillOps; i++) begin
            a = addr_t'(i * 4);
            issueOp(1'b1, LEN_WORD, a, fillWord(a));
        end

        for (int i = 0; i < storeOps; i++) begin
            randomOp(1'b1);
        end
        for (int i = 0; i < loadRounds; i++) begin
            drawAddr(a);
            issueOp(1'b0, LEN_BYTE, a, '0);
            issueOp(1'b0, LEN_HALF, a, '0);
            issueOp(1'b0, LEN_WORD, a, '0);
        end

        // narrow store inside a word, neighbours checked by the word load
        for (int i = 0; i < partialRounds; i++) begin
            drawAddr(a);
            seed = lcgNext(seed);
            issueOp(1'b1, LEN_WORD, a, seed);
            seed = lcgNext(seed);
            issueOp(1'b1, seed[29] ? LEN_BYTE : LEN_HALF,
                    a + addr_t'((seed[31:30] == 2'd3) ? 2'd1 : seed[31:30]), seed);
            issueOp(1'b0, LEN_WORD, a, '0);
        end

        @(posedge clk);
        fetchEn <= 1'b1;
        wait (instCount >= fetchTarget);

        fetchMark = instCount;
        for (int i = 0; i < concOps; i++) begin
            randomOp(1'b0);
        end
        streamOk = instCount > fetchMark;
        @(posedge clk);
        fetchEn <= 1'b0;

        @(posedge clk);
        freezeOn <= 1'b1;
        for (int i = 0; i < freezeOps; i++) begin
            randomOp(1'b0);
        end
        @(posedge clk);
        freezeOn <= 1'b0;
        repeat (10) @(posedge clk);

        if (!streamOk) begin
            $display("no instructions were delivered while load/store traffic ran");
        end
        if (expQ.size() != 0 || doneCount != issued) begin
            $display("%0d commands issued but %0d done pulses seen", issued, doneCount);
        end
        if (streamOk && expQ.size() == 0 && doneCount == issued) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "final checks failed");
        end
    end

endmodule

/* hw/byteRam.sv */
`timescale 1ns/1ps

module byteRam #(
    parameter int addrWidth = 16
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [addrWidth-1:0] addr,
    input  memPkg::byte_t        wdata,
    output memPkg::byte_t        rdata
);
    import memPkg::*;

    byte_t mem [2**addrWidth];

    // read-first, data appears one clock after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* hw/instFetch.sv */
`timescale 1ns/1ps

module instFetch #(
    parameter int addrWidth = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetchEn,
    input  logic                 pcLoad,
    input  logic [addrWidth-1:0] pcValue,
    input  logic                 instDone,
    input  memPkg::word_t        instWord,
    output logic                 instReq,
    output logic [addrWidth-1:0] instAddr,
    output logic                 instValid,
    output memPkg::word_t        instOut,
    output logic [addrWidth-1:0] instPc,
    output logic                 bpValid,
    output memPkg::word_t        bpInst
);
    logic [addrWidth-1:0] pc;
    logic [addrWidth-1:0] redirectPc;
    logic                 reqActive;
    logic                 kill;

    assign instReq  = reqActive;
    assign instAddr = pc;

    // predictor tap sees the same instruction
    assign bpValid = instValid;
    assign bpInst  = instOut;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            reqActive <= 1'b0;
            kill      <= 1'b0;
            instValid <= 1'b0;
        end else begin
            instValid <= instDone && !kill && !pcLoad;

            // request stays up until its done, then follows fetchEn
            if (!reqActive || instDone) begin
                reqActive <= fetchEn;
            end

            if (pcLoad && reqActive && !instDone) begin
                // address must stay stable, so finish the old fetch silently
                kill <= 1'b1;
            end else if (pcLoad) begin
                pc   <= pcValue;
                kill <= 1'b0;
            end else if (instDone) begin
                kill <= 1'b0;
                pc   <= kill ? redirectPc : pc + addrWidth'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pcLoad) begin
            redirectPc <= pcValue;
        end
        if (instDone) begin
            instOut <= instWord;
            instPc  <= pc;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (rst)
        instReq |-> instAddr[1:0] == 2'b00);

endmodule

/* hw/loadStore.sv */
`timescale 1ns/1ps

module loadStore #(
    parameter int addrWidth = 16
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 cmdValid,
    input  logic                 cmdStore,
    input  memPkg::accessLen_e   cmdLen,
    input  logic [addrWidth-1:0] cmdAddr,
    input  memPkg::word_t        cmdData,
    output logic                 lsBusy,
    output logic                 lsDone,
    output memPkg::word_t        lsRdata,

    output logic                 dataReq,
    output logic                 dataStore,
    output memPkg::accessLen_e   dataLen,
    output logic [addrWidth-1:0] dataAddr,
    output memPkg::word_t        dataWdata,
    input  logic                 dataDone,
    input  memPkg::word_t        dataRdata
);
    logic pending;

    assign dataReq = pending;
    assign lsBusy  = pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            lsDone  <= 1'b0;
        end else begin
            lsDone <= pending && dataDone;
            if (cmdValid) begin
                pending <= 1'b1;
            end else if (dataDone) begin
                pending <= 1'b0;
            end
        end
    end

    // held request and returned result
    always_ff @(posedge clk) begin
        if (cmdValid && !pending) begin
            dataStore <= cmdStore;
            dataLen   <= cmdLen;
            dataAddr  <= cmdAddr;
            dataWdata <= cmdData;
        end
        if (pending && dataDone) begin
            lsRdata <= dataStore ? '0 : dataRdata;
        end
    end

    noCmdWhileBusy: assert property (@(posedge clk) disable iff (rst)
        cmdValid |-> !pending);

endmodule

/* hw/memCtrl.sv */
`timescale 1ns/1ps

module memCtrl #(
    parameter int addrWidth = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,

    input  logic                 instReq,
    input  logic [addrWidth-1:0] instAddr,
    output logic                 instDone,
    output memPkg::word_t        instWord,

    input  logic                 dataReq,
    input  logic                 dataStore,
    input  memPkg::accessLen_e   dataLen,
    input  logic [addrWidth-1:0] dataAddr,
    input  memPkg::word_t        dataWdata,
    output logic                 dataDone,
    output memPkg::word_t        dataRdata,

    output logic                 ramWe,
    output logic [addrWidth-1:0] ramAddr,
    output memPkg::byte_t        ramWdata,
    input  memPkg::byte_t        ramRdata
);
    import memPkg::*;

    memOwner_e            owner;
    logic [2:0]           stage;
    logic [addrWidth-1:0] addrQ;
    accessLen_e           lenQ;
    logic                 storeQ;
    word_t                wordBuf;

    logic                 frozen;
    logic                 dataSel;
    logic                 instSel;
    logic                 curStore;
    accessLen_e           curLen;
    logic [2:0]           lastStoreStage;
    logic                 lastStore;
    logic                 lastLoad;
    logic                 lastInst;
    logic [addrWidth-1:0] baseAddr;
    logic [2:0]           addrOffset;
    logic [1:0]           lane;
    word_t                loadWord;

    assign frozen = !rdy || ioBufferFull;

    // in idle the request itself drives the RAM, data first
    assign dataSel = (owner == OWNER_DATA) || (owner == OWNER_NONE && dataReq);
    assign instSel = (owner == OWNER_INST) || (owner == OWNER_NONE && !dataReq && instReq);

    assign curStore = (owner == OWNER_NONE) ? dataStore : storeQ;
    assign curLen   = (owner == OWNER_NONE) ? dataLen : lenQ;

    assign lastStoreStage = curLen - 3'd1;
    assign lastStore      = dataSel && curStore && stage == lastStoreStage;
    assign lastLoad       = dataSel && !curStore && stage == curLen;
    assign lastInst       = instSel && stage == 3'd4;

    always_comb begin
        if (owner != OWNER_NONE) begin
            baseAddr = addrQ;
        end else if (dataReq) begin
            baseAddr = dataAddr;
        end else begin
            baseAddr = instAddr;
        end
    end

    // a frozen load keeps the awaited byte on ramRdata by re-reading it
    assign addrOffset = (frozen && stage != 3'd0) ? stage - 3'd1 : stage;
    assign ramAddr    = baseAddr + addrWidth'(addrOffset);

    assign ramWe    = !frozen && dataSel && curStore;
    assign ramWdata = dataWdata[{stage[1:0], 3'b000} +: 8];

    // byte from the previous cycle lands in lane stage-1
    assign lane = stage[1:0] - 2'd1;

    always_comb begin
        loadWord = wordBuf;
        loadWord[{lane, 3'b000} +: 8] = ramRdata;
    end

    assign dataDone  = !frozen && (lastStore || lastLoad);
    assign dataRdata = loadWord;
    assign instDone  = !frozen && lastInst;
    assign instWord  = loadWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWNER_NONE;
            stage <= 3'd0;
        end else if (!frozen) begin
            case (owner)
                OWNER_NONE: begin
                    if (dataReq) begin
                        // single byte stores finish in the grant cycle
                        if (!lastStore) begin
                            owner <= OWNER_DATA;
                            stage <= 3'd1;
                        end
                    end else if (instReq) begin
                        owner <= OWNER_INST;
                        stage <= 3'd1;
                    end
                end
                OWNER_DATA: begin
                    if (lastStore || lastLoad) begin
                        owner <= OWNER_NONE;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                OWNER_INST: begin
                    if (lastInst) begin
                        owner <= OWNER_NONE;
                        stage <= 3'd0;
                    end else begin
                        stage <= stage + 3'd1;
                    end
                end
                default: begin
                    owner <= OWNER_NONE;
                    stage <= 3'd0;
                end
            endcase
        end
    end

    // access attributes and byte buffer
    always_ff @(posedge clk) begin
        if (!frozen) begin
            if (owner == OWNER_NONE) begin
                addrQ   <= baseAddr;
                lenQ    <= dataReq ? dataLen : LEN_WORD;
                storeQ  <= dataReq && dataStore;
                wordBuf <= '0;
            end else begin
                wordBuf <= loadWord;
            end
        end
    end

    // a done pulse goes only to a requester still asking, never to both
    doneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(dataDone && instDone) && (!dataDone || dataReq) && (!instDone || instReq));

    noInstWrite: assert property (@(posedge clk) disable iff (rst)
        ramWe |-> owner != OWNER_INST && dataReq && dataStore);

    legalLen: assert property (@(posedge clk) disable iff (rst)
        dataReq |-> dataLen inside {LEN_BYTE, LEN_HALF, LEN_WORD});

endmodule

/* hw/memPkg.sv */
package memPkg;

    // instruction and data words
    typedef logic [31:0] word_t;

    // one RAM data lane
    typedef logic [7:0] byte_t;

    // byte count of one access
    typedef enum logic [2:0] {
        LEN_BYTE = 3'd1,
        LEN_HALF = 3'd2,
        LEN_WORD = 3'd4
    } accessLen_e;

    // current holder of the RAM port
    typedef enum logic [1:0] {
        OWNER_NONE = 2'd0,
        OWNER_DATA = 2'd1,
        OWNER_INST = 2'd2
    } memOwner_e;

endpackage

/* hw/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem #(
    parameter int addrWidth = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,

    input  logic                 fetchEn,
    input  logic                 pcLoad,
    input  logic [addrWidth-1:0] pcValue,
    output logic                 instValid,
    output memPkg::word_t        instOut,
    output logic [addrWidth-1:0] instPc,
    output logic                 bpValid,
    output memPkg::word_t        bpInst,

    input  logic                 cmdValid,
    input  logic                 cmdStore,
    input  memPkg::accessLen_e   cmdLen,
    input  logic [addrWidth-1:0] cmdAddr,
    input  memPkg::word_t        cmdData,
    output logic                 lsBusy,
    output logic                 lsDone,
    output memPkg::word_t        lsRdata
);
    import memPkg::*;

    logic                 instReq;
    logic [addrWidth-1:0] instAddr;
    logic                 instDone;
    word_t                instWord;

    logic                 dataReq;
    logic                 dataStore;
    accessLen_e           dataLen;
    logic [addrWidth-1:0] dataAddr;
    word_t                dataWdata;
    logic                 dataDone;
    word_t                dataRdata;

    logic                 ramWe;
    logic [addrWidth-1:0] ramAddr;
    byte_t                ramWdata;
    byte_t                ramRdata;

    instFetch #(
        .addrWidth(addrWidth)
    ) fetch (
        .clk      (clk),
        .rst      (rst),
        .fetchEn  (fetchEn),
        .pcLoad   (pcLoad),
        .pcValue  (pcValue),
        .instDone (instDone),
        .instWord (instWord),
        .instReq  (instReq),
        .instAddr (instAddr),
        .instValid(instValid),
        .instOut  (instOut),
        .instPc   (instPc),
        .bpValid  (bpValid),
        .bpInst   (bpInst)
    );

    loadStore #(
        .addrWidth(addrWidth)
    ) lsPort (
        .clk      (clk),
        .rst      (rst),
        .cmdValid (cmdValid),
        .cmdStore (cmdStore),
        .cmdLen   (cmdLen),
        .cmdAddr  (cmdAddr),
        .cmdData  (cmdData),
        .lsBusy   (lsBusy),
        .lsDone   (lsDone),
        .lsRdata  (lsRdata),
        .dataReq  (dataReq),
        .dataStore(dataStore),
        .dataLen  (dataLen),
        .dataAddr (dataAddr),
        .dataWdata(dataWdata),
        .dataDone (dataDone),
        .dataRdata(dataRdata)
    );

    memCtrl #(
        .addrWidth(addrWidth)
    ) ctrl (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioBufferFull(ioBufferFull),
        .instReq     (instReq),
        .instAddr    (instAddr),
        .instDone    (instDone),
        .instWord    (instWord),
        .dataReq     (dataReq),
        .dataStore   (dataStore),
        .dataLen     (dataLen),
        .dataAddr    (dataAddr),
        .dataWdata   (dataWdata),
        .dataDone    (dataDone),
        .dataRdata   (dataRdata),
        .ramWe       (ramWe),
        .ramAddr     (ramAddr),
        .ramWdata    (ramWdata),
        .ramRdata    (ramRdata)
    );

    byteRam #(
        .addrWidth(addrWidth)
    ) ram (
        .clk  (clk),
        .we   (ramWe),
        .addr (ramAddr),
        .wdata(ramWdata),
        .rdata(ramRdata)
    );

endmodule

/* src.f */
hw/memPkg.sv
hw/byteRam.sv
hw/memCtrl.sv
hw/instFetch.sv
hw/loadStore.sv
hw/memSubsystem.sv
bench/tbMemSubsystem.sv
